// ==== Makefile ====
TOP := n64_video_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -sv --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary -sv --timing --assert -f vlog.f --top-module $(TOP) -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/n64_cfg_axil.sv ====
`timescale 1ns/1ps
`include "n64a_defs.svh"

module n64_cfg_axil (
  input  logic                      nCLK,
  input  logic                      nRST,
  // write address
  input  logic [`AXIL_AW-1:0]       s_awaddr_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  // write data
  input  logic [`AXIL_DW-1:0]       s_wdata_i,
  input  logic [`AXIL_DW/8-1:0]     s_wstrb_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  // write response
  output logic [1:0]                s_bresp_o,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  // read address
  input  logic [`AXIL_AW-1:0]       s_araddr_i,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  // read data
  output logic [`AXIL_DW-1:0]       s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  // estimator side
  output n64_cfg_pkg::deblur_ctrl_t ctrl_o,
  input  n64_cfg_pkg::deblur_stat_t stat_i
);

  import n64_cfg_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  axil_state_e         state_q;
  deblur_ctrl_t        ctrl_q;
  logic [1:0]          bresp_q;
  logic [1:0]          rresp_q;
  logic [`AXIL_DW-1:0] rdata_q;
  logic                idle;
  logic                wr_both;    // address and data both offered
  logic                wr_go;
  logic                rd_go;
  logic                wr_hit;
  logic                rd_hit;

  assign idle    = (state_q == ST_IDLE);
  assign wr_both = s_awvalid_i & s_wvalid_i;
  assign wr_go   = idle & wr_both;
  assign rd_go   = idle & s_arvalid_i & ~wr_both;  // write has priority
  assign wr_hit  = (s_awaddr_i == `REG_CTRL) || (s_awaddr_i == `REG_STATUS);
  assign rd_hit  = (s_araddr_i == `REG_CTRL) || (s_araddr_i == `REG_STATUS);

  //////////////////////////////////////////////////
  // handshake FSM

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_go)
            state_q <= ST_WRESP;
          else if (rd_go)
            state_q <= ST_RDATA;
        end
        ST_WRESP: if (s_bready_i) state_q <= ST_IDLE;  // hold under back-pressure
        ST_RDATA: if (s_rready_i) state_q <= ST_IDLE;
        default:  state_q <= ST_IDLE;
      endcase
    end
  end

  // control register, status address is read only
  always_ff @(negedge nCLK) begin
    if (!nRST)
      ctrl_q <= 2'b11;                       // automatic mode
    else if (wr_go && (s_awaddr_i == `REG_CTRL) && s_wstrb_i[0])
      ctrl_q <= deblur_ctrl_t'(s_wdata_i[1:0]);
  end

  // response payload, captured at acceptance
  always_ff @(negedge nCLK) begin
    if (wr_go)
      bresp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    if (rd_go) begin
      rresp_q <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      case (s_araddr_i)
        `REG_CTRL:   rdata_q <= {{(`AXIL_DW-2){1'b0}}, ctrl_q};
        `REG_STATUS: rdata_q <= {{(`AXIL_DW-3){1'b0}}, stat_i};
        default:     rdata_q <= '0;          // unmapped reads as zero
      endcase
    end
  end

  assign s_awready_o = wr_go;
  assign s_wready_o  = wr_go;
  assign s_arready_o = idle & ~wr_both;
  assign s_bvalid_o  = (state_q == ST_WRESP);
  assign s_bresp_o   = bresp_q;
  assign s_rvalid_o  = (state_q == ST_RDATA);
  assign s_rresp_o   = rresp_q;
  assign s_rdata_o   = rdata_q;
  assign ctrl_o      = ctrl_q;

endmodule

// ==== hdl/n64_cfg_pkg.sv ====
`include "n64a_defs.svh"

package n64_cfg_pkg;

  // control register, bit 1 down to bit 0
  typedef struct packed {
    logic nforce_deblur;  // 1: automatic, 0: manual
    logic ndeblur_man;    // manual value of ndo_deblur
  } deblur_ctrl_t;

  // estimator status, same order as the status register bits 2:0
  typedef struct packed {
    logic trend_msb;
    logic n64_480i;
    logic ndo_deblur;
  } deblur_stat_t;

  // register block FSM
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_WRESP = 2'd1,  // write accepted, bvalid up
    ST_RDATA = 2'd2   // read accepted, rvalid up
  } axil_state_e;

endpackage

// ==== hdl/n64_deblur.sv ====
`timescale 1ns/1ps
`include "n64a_defs.svh"

module n64_deblur (
  input  logic                        nCLK,
  input  logic                        nRST,
  input  n64_video_pkg::vbus_t        vbus_i,
  input  n64_cfg_pkg::deblur_ctrl_t   ctrl_i,
  output logic                        ndo_deblur_o,
  output n64_cfg_pkg::deblur_stat_t   stat_o
);

  import n64_video_pkg::*;
  import n64_cfg_pkg::*;

  localparam int TREND_MSB = `TREND_W - 1;
  localparam int CMP_MSB   = `COLOR_W - 1;

  logic                blur_pix_q;   // 1: prev group is the blur pixel
  logic                run_est_q;    // skip first frame after reset / 480i
  logic [1:0]          grad_q [0:2]; // {down, up} per colour, r g b
  logic [2:0]          chg_q;        // colour reversed on this pair
  logic [1:0]          est_cnt_q;    // qualifying pairs this frame, sat. at 3
  logic [`TREND_W-1:0] trend_q;      // simple mean filter over frames
  deblur_stat_t        stat_q;       // trend_msb doubles as nblur

  logic [1:0]          col_idx;
  logic [2:0]          pre_top;
  logic [2:0]          cur_top;
  logic [1:0]          grad_now;
  logic                col_cycle;

  //////////////////////////////////////////////////
  // colour select, one colour per bus cycle

  always_comb begin
    case (vbus_i.phase)
      PH_R: begin
        col_idx = 2'd0;
        pre_top = vbus_i.prev.r[CMP_MSB -: 3];
        cur_top = vbus_i.cur.r[CMP_MSB -: 3];
      end
      PH_G: begin
        col_idx = 2'd1;
        pre_top = vbus_i.prev.g[CMP_MSB -: 3];
        cur_top = vbus_i.cur.g[CMP_MSB -: 3];
      end
      default: begin                  // PH_B, PH_SYNC masked by col_cycle
        col_idx = 2'd2;
        pre_top = vbus_i.prev.b[CMP_MSB -: 3];
        cur_top = vbus_i.cur.b[CMP_MSB -: 3];
      end
    endcase
  end

  assign grad_now  = {cur_top < pre_top, cur_top > pre_top};  // flat -> 00
  assign col_cycle = ~vbus_i.group_start & (vbus_i.phase != PH_SYNC);

  //////////////////////////////////////////////////
  // heuristic and decision

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      blur_pix_q <= 1'b0;
      run_est_q  <= 1'b0;
      grad_q     <= '{default: 2'b00};
      chg_q      <= 3'b000;
      est_cnt_q  <= 2'b00;
      trend_q    <= `TREND_INIT;
      stat_q     <= '{trend_msb: 1'b1, n64_480i: 1'b0, ndo_deblur: 1'b1};
    end else if (vbus_i.group_start) begin
      blur_pix_q <= vbus_i.line_start ? 1'b0 : ~blur_pix_q;  // restart phase per line
      if (vbus_i.line_start)
        grad_q <= '{default: 2'b00};         // no pair across the line border
      if (!blur_pix_q)
        chg_q <= 3'b000;                     // pair done, start over

      if (vbus_i.new_frame) begin
        est_cnt_q         <= 2'b00;
        stat_q.n64_480i   <= vbus_i.n64_480i;
        stat_q.ndo_deblur <= vbus_i.n64_480i |
                             (ctrl_i.nforce_deblur ? trend_q[TREND_MSB] : ctrl_i.ndeblur_man);
        if (vbus_i.n64_480i) begin
          run_est_q <= 1'b0;                 // no estimation in interlace
        end else begin
          run_est_q        <= 1'b1;
          stat_q.trend_msb <= trend_q[TREND_MSB];  // nblur, old msb
          if (run_est_q && est_cnt_q[1])     // two or more pairs -> sharp
            trend_q <= &trend_q ? trend_q : trend_q + 1'b1;
          else
            trend_q <= |trend_q ? trend_q - 1'b1 : trend_q;
        end
      end else if (!blur_pix_q && (&chg_q) && !(&est_cnt_q)) begin
        est_cnt_q <= est_cnt_q + 2'd1;       // all three colours reversed
      end
    end else if (col_cycle) begin
      if (blur_pix_q)
        grad_q[col_idx] <= grad_now;         // direction blur pixel -> next
      else if (&(grad_q[col_idx] ^ grad_now))
        chg_q[col_idx] <= 1'b1;              // strict reversal only
    end
  end

  assign stat_o       = stat_q;
  assign ndo_deblur_o = stat_q.ndo_deblur;

endmodule

// ==== hdl/n64_video_pkg.sv ====
`include "n64a_defs.svh"

package n64_video_pkg;

  // sync nibble as it sits on D[3:0], msb first
  typedef struct packed {
    logic nvsync;
    logic nclamp;
    logic nhsync;
    logic ncsync;
  } sync_nib_t;

  // one complete group: sync word plus the three colours
  typedef struct packed {
    sync_nib_t            sync;
    logic [`COLOR_W-1:0]  r;
    logic [`COLOR_W-1:0]  g;
    logic [`COLOR_W-1:0]  b;
  } vgroup_t;

  // word taken on the last falling edge
  typedef enum logic [1:0] {
    PH_SYNC = 2'd0,
    PH_R    = 2'd1,
    PH_G    = 2'd2,
    PH_B    = 2'd3
  } bus_phase_e;

  // demux -> estimator
  typedef struct packed {
    vgroup_t    cur;          // group just completed
    vgroup_t    prev;         // group before that
    bus_phase_e phase;
    logic       new_frame;    // falling nVSYNC
    logic       line_start;   // rising nCSYNC
    logic       group_start;  // nDSYNC was low on the last edge
    logic       n64_480i;
  } vbus_t;

endpackage

// ==== hdl/n64_video_top.sv ====
`timescale 1ns/1ps
`include "n64a_defs.svh"

module n64_video_top (
  input  logic                  nCLK,
  input  logic                  nRST,
  // N64 video bus
  input  logic                  nDSYNC_i,
  input  logic [`COLOR_W-1:0]   D_i,
  // host register port
  input  logic [`AXIL_AW-1:0]   s_awaddr_i,
  input  logic                  s_awvalid_i,
  output logic                  s_awready_o,
  input  logic [`AXIL_DW-1:0]   s_wdata_i,
  input  logic [`AXIL_DW/8-1:0] s_wstrb_i,
  input  logic                  s_wvalid_i,
  output logic                  s_wready_o,
  output logic [1:0]            s_bresp_o,
  output logic                  s_bvalid_o,
  input  logic                  s_bready_i,
  input  logic [`AXIL_AW-1:0]   s_araddr_i,
  input  logic                  s_arvalid_i,
  output logic                  s_arready_o,
  output logic [`AXIL_DW-1:0]   s_rdata_o,
  output logic [1:0]            s_rresp_o,
  output logic                  s_rvalid_o,
  input  logic                  s_rready_i,
  // to the DAC blanking
  output logic                  ndo_deblur_o
);

  import n64_video_pkg::*;
  import n64_cfg_pkg::*;

  vbus_t        vbus;    // demux -> estimator
  deblur_ctrl_t ctrl;    // host -> estimator
  deblur_stat_t stat;    // estimator -> host

  //////////////////////////////////////////////////
  // video path

  n64_vinfo_demux demux_i (
    .nCLK     (nCLK),
    .nRST     (nRST),
    .nDSYNC_i (nDSYNC_i),
    .D_i      (D_i),
    .vbus_o   (vbus)
  );

  n64_deblur deblur_i (
    .nCLK         (nCLK),
    .nRST         (nRST),
    .vbus_i       (vbus),
    .ctrl_i       (ctrl),
    .ndo_deblur_o (ndo_deblur_o),
    .stat_o       (stat)
  );

  //////////////////////////////////////////////////
  // host registers

  n64_cfg_axil cfg_i (
    .nCLK        (nCLK),
    .nRST        (nRST),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .ctrl_o      (ctrl),
    .stat_i      (stat)
  );

endmodule

// ==== hdl/n64_vinfo_demux.sv ====
`timescale 1ns/1ps
`include "n64a_defs.svh"

module n64_vinfo_demux (
  input  logic                 nCLK,
  input  logic                 nRST,
  input  logic                 nDSYNC_i,
  input  logic [`COLOR_W-1:0]  D_i,
  output n64_video_pkg::vbus_t vbus_o
);

  import n64_video_pkg::*;

  vgroup_t    asm_q;           // group under assembly
  vgroup_t    cur_q;
  vgroup_t    prev_q;
  bus_phase_e phase_q;
  logic       group_start_q;
  logic       new_frame_q;
  logic       line_start_q;
  logic       vs_hs_lvl_q;     // nHSYNC level seen at the last vsync
  logic       vs_seen_q;       // a frame start has been seen since reset
  logic       n64_480i_q;
  logic       negedge_nvsync;
  logic       posedge_ncsync;

  // edges between the completed group and the one before it
  assign negedge_nvsync =  cur_q.sync.nvsync & ~asm_q.sync.nvsync;
  assign posedge_ncsync = ~cur_q.sync.ncsync &  asm_q.sync.ncsync;

  //////////////////////////////////////////////////
  // word capture

  always_ff @(negedge nCLK) begin
    if (!nDSYNC_i) begin
      asm_q.sync <= sync_nib_t'(D_i[3:0]);  // sync sits in the low nibble
    end else begin
      case (phase_q)
        PH_SYNC: asm_q.r <= D_i;
        PH_R:    asm_q.g <= D_i;
        PH_G:    asm_q.b <= D_i;
        default: ;                           // no group framing, wait
      endcase
    end
  end

  //////////////////////////////////////////////////
  // framing, group shift, 480i

  always_ff @(negedge nCLK) begin
    if (!nRST) begin
      phase_q       <= PH_B;                 // idle until first nDSYNC
      cur_q         <= '0;
      prev_q        <= '0;
      group_start_q <= 1'b0;
      new_frame_q   <= 1'b0;
      line_start_q  <= 1'b0;
      vs_hs_lvl_q   <= 1'b0;
      vs_seen_q     <= 1'b0;
      n64_480i_q    <= 1'b0;
    end else begin
      group_start_q <= ~nDSYNC_i;
      new_frame_q   <= ~nDSYNC_i & negedge_nvsync;
      line_start_q  <= ~nDSYNC_i & posedge_ncsync;
      if (!nDSYNC_i) begin
        phase_q <= PH_SYNC;
        prev_q  <= cur_q;
        cur_q   <= asm_q;                    // R, G, B all in now
        if (negedge_nvsync) begin            // frame start
          vs_hs_lvl_q <= asm_q.sync.nhsync;
          vs_seen_q   <= 1'b1;
          if (vs_seen_q)
            n64_480i_q <= asm_q.sync.nhsync ^ vs_hs_lvl_q;  // phase flips in interlace
        end
      end else begin
        case (phase_q)
          PH_SYNC: phase_q <= PH_R;
          PH_R:    phase_q <= PH_G;
          default: phase_q <= PH_B;          // hold after B
        endcase
      end
    end
  end

  assign vbus_o = '{cur:         cur_q,
                    prev:        prev_q,
                    phase:       phase_q,
                    new_frame:   new_frame_q,
                    line_start:  line_start_q,
                    group_start: group_start_q,
                    n64_480i:    n64_480i_q};

endmodule

// ==== hdl/n64a_defs.svh ====
`ifndef N64A_DEFS_SVH
`define N64A_DEFS_SVH

//////////////////////////////////////////////////
// video bus

`define COLOR_W    7        // one colour word on the N64 bus

//////////////////////////////////////////////////
// blur estimation

`define TREND_W    9        // trend filter width
`define TREND_INIT 9'h100   // msb set, rest zero -> starts at "no blur"

//////////////////////////////////////////////////
// host register port

`define AXIL_AW    4        // byte address width
`define AXIL_DW    32       // data width
`define REG_CTRL   4'h0     // {nforce_deblur, ndeblur_man}
`define REG_STATUS 4'h4     // {trend_msb, n64_480i, ndo_deblur}

`endif

// ==== tb/n64_video_sva.sv ====
`timescale 1ns/1ps

module n64_video_sva (
  input logic nCLK,
  input logic nRST,
  input logic awvalid_i,
  input logic awready_i,
  input logic wvalid_i,
  input logic wready_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic new_frame_i,
  input logic ndo_deblur_i,
  input logic n64_480i_i
);

  //////////////////////////////////////////////////
  // valid holds on every channel until taken

  a_aw_hold: assert property (@(negedge nCLK) disable iff (!nRST)
    awvalid_i && !awready_i |=> awvalid_i) else $error("awvalid dropped before awready");
  a_w_hold:  assert property (@(negedge nCLK) disable iff (!nRST)
    wvalid_i && !wready_i |=> wvalid_i) else $error("wvalid dropped before wready");
  a_ar_hold: assert property (@(negedge nCLK) disable iff (!nRST)
    arvalid_i && !arready_i |=> arvalid_i) else $error("arvalid dropped before arready");
  a_b_hold:  assert property (@(negedge nCLK) disable iff (!nRST)
    bvalid_i && !bready_i |=> bvalid_i) else $error("bvalid dropped before bready");
  a_r_hold:  assert property (@(negedge nCLK) disable iff (!nRST)
    rvalid_i && !rready_i |=> rvalid_i) else $error("rvalid dropped before rready");

  //////////////////////////////////////////////////
  // deblur decision

  a_ndo_frame: assert property (@(negedge nCLK) disable iff (!nRST)
    $changed(ndo_deblur_i) |-> $past(new_frame_i)) else $error("ndo_deblur moved mid frame");
  // demux flag moves with the frame strobe, decision follows one edge later
  a_ndo_480i: assert property (@(negedge nCLK) disable iff (!nRST)
    n64_480i_i && !new_frame_i |-> ndo_deblur_i) else $error("ndo_deblur low in 480i");

endmodule

// host side with the video ports tied off
bind n64_cfg_axil n64_video_sva axil_sva_i (
  .nCLK (nCLK), .nRST (nRST),
  .awvalid_i (s_awvalid_i), .awready_i (s_awready_o),
  .wvalid_i (s_wvalid_i), .wready_i (s_wready_o),
  .arvalid_i (s_arvalid_i), .arready_i (s_arready_o),
  .bvalid_i (s_bvalid_o), .bready_i (s_bready_i),
  .rvalid_i (s_rvalid_o), .rready_i (s_rready_i),
  .new_frame_i (1'b0), .ndo_deblur_i (1'b1), .n64_480i_i (1'b0)
);

// estimator side with the handshake ports tied off
bind n64_deblur n64_video_sva deblur_sva_i (
  .nCLK (nCLK), .nRST (nRST),
  .awvalid_i (1'b0), .awready_i (1'b0), .wvalid_i (1'b0), .wready_i (1'b0),
  .arvalid_i (1'b0), .arready_i (1'b0), .bvalid_i (1'b0), .bready_i (1'b0),
  .rvalid_i (1'b0), .rready_i (1'b0),
  .new_frame_i (vbus_i.new_frame), .ndo_deblur_i (ndo_deblur_o),
  .n64_480i_i (vbus_i.n64_480i)
);

// ==== tb/n64_video_tb.sv ====
`timescale 1ns/1ps
`include "n64a_defs.svh"

module n64_video_tb;

  logic                  nCLK;
  logic                  nRST;
  logic                  nDSYNC;
  logic [`COLOR_W-1:0]   D;
  logic [`AXIL_AW-1:0]   awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [`AXIL_DW-1:0]   wdata;
  logic [`AXIL_DW/8-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [`AXIL_AW-1:0]   araddr;
  logic                  arvalid;
  logic                  arready;
  logic [`AXIL_DW-1:0]   rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  ndo_deblur;

  int          err_cnt;
  int          test_cnt;
  logic [31:0] lfsr_q;
  logic        zig_q;          // zigzag colour toggle
  logic [8:0]  trend_m;        // reference trend
  logic        run_m;          // reference estimation enable

  n64_video_top dut_i (
    .nCLK (nCLK), .nRST (nRST), .nDSYNC_i (nDSYNC), .D_i (D),
    .s_awaddr_i (awaddr), .s_awvalid_i (awvalid), .s_awready_o (awready),
    .s_wdata_i (wdata), .s_wstrb_i (wstrb), .s_wvalid_i (wvalid), .s_wready_o (wready),
    .s_bresp_o (bresp), .s_bvalid_o (bvalid), .s_bready_i (bready),
    .s_araddr_i (araddr), .s_arvalid_i (arvalid), .s_arready_o (arready),
    .s_rdata_o (rdata), .s_rresp_o (rresp), .s_rvalid_o (rvalid), .s_rready_i (rready),
    .ndo_deblur_o (ndo_deblur)
  );

  always #10 nCLK = ~nCLK;     // 20 ns period

  // fibonacci lfsr on taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic apply_reset();
    nRST    <= 1'b0;
    repeat (10) @(posedge nCLK);
    nRST    <= 1'b1;
    trend_m = 9'h100;
    run_m   = 1'b0;
    @(posedge nCLK);
  endtask

  //////////////////////////////////////////////////
  // video stream

  // one group with sync nibble {nvsync, nclamp, nhsync, ncsync} then R G B
  task automatic send_group(input logic [3:0] nib, input logic sharp);
    logic [`COLOR_W-1:0] c;
    zig_q = ~zig_q;
    c = sharp ? (zig_q ? 7'h70 : 7'h10) : 7'h40;
    @(posedge nCLK);
    nDSYNC <= 1'b0;
    D      <= {3'b000, nib};
    @(posedge nCLK);
    nDSYNC <= 1'b1;
    D      <= c;
    @(posedge nCLK);
    D      <= c;
    @(posedge nCLK);
    D      <= c;
  endtask

  // 3 lines of 8 pixels then vsync and a blank group
  // frame start is seen as the blank group begins
  task automatic send_frame(input logic hs, input logic sharp);
    for (int l = 0; l < 3; l++) begin
      send_group(4'b1100, sharp);            // line sync with ncsync low
      for (int p = 0; p < 8; p++)
        send_group(4'b1111, sharp);
    end
    send_group({2'b01, hs, 1'b0}, sharp);    // vsync with chosen nhsync phase
    send_group({2'b01, hs, 1'b0}, sharp);    // blank
  endtask

  //////////////////////////////////////////////////
  // AXI4-Lite master

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            input int hold, output logic [1:0] resp);
    int t;
    @(posedge nCLK);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= 4'hf;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    bready  <= (hold == 0);
    t = 0;
    do begin
      @(posedge nCLK);
      t++;
      if (t > 100) abort_run("timeout: write never accepted");
    end while (!bvalid);
    resp = bresp;
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    for (int i = 0; i < hold; i++) begin   // back-pressure
      @(posedge nCLK);
      if (!bvalid) begin
        err_cnt++;
        $display("[FAIL] %0t bvalid dropped while bready low", $time);
      end
    end
    bready <= 1'b1;
    t = 0;
    do begin
      @(posedge nCLK);
      t++;
      if (t > 100) abort_run("timeout: write response never completed");
    end while (bvalid);
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int t;
    @(posedge nCLK);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    t = 0;
    do begin
      @(posedge nCLK);
      t++;
      if (t > 100) abort_run("timeout: read data never returned");
    end while (!rvalid);
    data = rdata;
    resp = rresp;
    arvalid <= 1'b0;
    t = 0;
    do begin
      @(posedge nCLK);
      t++;
      if (t > 100) abort_run("timeout: read channel never returned to idle");
    end while (rvalid);
    rready <= 1'b0;
  endtask

  task automatic expect_reg(input logic [3:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] d;
    logic [1:0]  r;
    axil_read(addr, d, r);
    if (d !== exp || r !== 2'b00) begin
      err_cnt++;
      $display("[FAIL] %0t %s: read %h resp %b, expected %h", $time, what, d, r, exp);
    end
  endtask

  task automatic expect_ndo(input logic exp, input string what);
    if (ndo_deblur !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t %s: ndo_deblur %b, expected %b", $time, what, ndo_deblur, exp);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %-10s ok", name);
    else
      $display("test %-10s %0d errors", name, err_cnt - err_before);
  endtask

  // steps the reference trend filter one frame and returns the new nblur
  function automatic logic model_frame(input logic sharp);
    logic nb;
    nb = trend_m[8];
    if (run_m && sharp)
      trend_m = (trend_m == 9'h1ff) ? trend_m : trend_m + 1;
    else
      trend_m = (trend_m == 9'h000) ? trend_m : trend_m - 1;
    run_m = 1'b1;
    return nb;
  endfunction

  //////////////////////////////////////////////////
  // directed tests

  task automatic test_reset();
    int e;
    e = err_cnt;
    expect_ndo(1'b1, "reset");
    if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
      err_cnt++;
      $display("[FAIL] %0t reset: bvalid %b rvalid %b", $time, bvalid, rvalid);
    end
    if (awready !== 1'b0 || wready !== 1'b0 || arready !== 1'b1) begin
      err_cnt++;
      $display("[FAIL] %0t reset: awready %b wready %b arready %b",
               $time, awready, wready, arready);
    end
    expect_reg(`REG_CTRL, 32'd3, "reset ctrl");
    expect_reg(`REG_STATUS, 32'd5, "reset status");
    end_test("reset", e);
  endtask

  task automatic test_regs();
    int          e;
    logic [31:0] v;
    logic [31:0] d;
    logic [1:0]  r;
    e = err_cnt;
    for (int k = 0; k < 4; k++) begin
      v = take_bits(32);
      axil_write(`REG_CTRL, v, 0, r);
      expect_reg(`REG_CTRL, {30'd0, v[1:0]}, "ctrl readback");
    end
    axil_write(4'h8, ~v, 0, r);             // inverted so a stray write shows
    if (r !== 2'b10) begin
      err_cnt++;
      $display("[FAIL] %0t unmapped write resp %b", $time, r);
    end
    expect_reg(`REG_CTRL, {30'd0, v[1:0]}, "unmapped write dropped");
    axil_read(4'h8, d, r);
    if (d !== 32'd0 || r !== 2'b10) begin
      err_cnt++;
      $display("[FAIL] %0t unmapped read %h resp %b", $time, d, r);
    end
    axil_write(`REG_CTRL, 32'd3, 3, r);     // held bready
    if (r !== 2'b00) begin
      err_cnt++;
      $display("[FAIL] %0t back-pressure write resp %b", $time, r);
    end
    end_test("regs", e);
  endtask

  task automatic test_manual();
    int         e;
    logic [1:0] r;
    e = err_cnt;
    axil_write(`REG_CTRL, 32'd0, 0, r);
    send_frame(1'b0, 1'b0);
    send_frame(1'b0, 1'b0);
    expect_ndo(1'b0, "manual 0");
    axil_write(`REG_CTRL, 32'd1, 0, r);
    send_frame(1'b0, 1'b0);
    expect_ndo(1'b1, "manual 1");
    end_test("manual", e);
  endtask

  task automatic test_480i();
    int          e;
    logic [31:0] d;
    logic [1:0]  r;
    e = err_cnt;
    axil_write(`REG_CTRL, 32'd0, 0, r);
    send_frame(1'b0, 1'b0);
    send_frame(1'b1, 1'b0);                  // flipped phase marks interlace
    axil_read(`REG_STATUS, d, r);
    if (d[1] !== 1'b1) begin
      err_cnt++;
      $display("[FAIL] %0t 480i flag not set, status %h", $time, d);
    end
    expect_ndo(1'b1, "480i forced");
    send_frame(1'b1, 1'b0);                  // same phase again
    axil_read(`REG_STATUS, d, r);
    if (d[1] !== 1'b0) begin
      err_cnt++;
      $display("[FAIL] %0t 480i flag not cleared, status %h", $time, d);
    end
    expect_ndo(1'b0, "240p manual 0");
    end_test("480i", e);
  endtask

  task automatic test_flat();
    int          e;
    logic        nb;
    logic [31:0] d;
    logic [1:0]  r;
    e = err_cnt;
    apply_reset();
    for (int f = 0; f < 3; f++) begin
      send_frame(1'b0, 1'b0);
      nb = model_frame(1'b0);
      expect_ndo(nb, "flat frame");
      axil_read(`REG_STATUS, d, r);
      if (d[2] !== nb) begin
        err_cnt++;
        $display("[FAIL] %0t flat trend_msb %b, expected %b", $time, d[2], nb);
      end
    end
    end_test("flat", e);
  endtask

  task automatic test_sharp();
    int          e;
    logic        nb;
    logic [31:0] d;
    logic [1:0]  r;
    e  = err_cnt;
    nb = 1'b0;
    for (int f = 0; f < 10 && !nb; f++) begin
      send_frame(1'b0, 1'b1);
      nb = model_frame(1'b1);
      expect_ndo(nb, "sharp frame");
      axil_read(`REG_STATUS, d, r);
      if (d[2] !== nb) begin
        err_cnt++;
        $display("[FAIL] %0t sharp trend_msb %b, expected %b", $time, d[2], nb);
      end
    end
    expect_ndo(1'b1, "sharp recovered");
    end_test("sharp", e);
  endtask

  initial begin
    nCLK    = 1'b0;
    nRST    = 1'b0;
    nDSYNC  = 1'b1;
    D       = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    err_cnt  = 0;
    test_cnt = 0;
    lfsr_q   = 32'h2d0ea6d4;
    zig_q    = 1'b0;
    apply_reset();
    test_reset();
    test_regs();
    test_manual();
    test_480i();
    test_flat();
    test_sharp();
    $display("tests %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+hdl
hdl/n64_video_pkg.sv
hdl/n64_cfg_pkg.sv
hdl/n64_vinfo_demux.sv
hdl/n64_deblur.sv
hdl/n64_cfg_axil.sv
hdl/n64_video_top.sv
tb/n64_video_sva.sv
tb/n64_video_tb.sv
